// File: verilog/plank_pkg.sv
package plank_pkg;

    localparam int NUM_CH         = 8;
    localparam int FRAME_BYTES    = 19;
    localparam int PAYLOAD_BYTES  = 18;
    localparam int FEEDBACK_BYTES = 3;

    localparam logic [7:0] FEEDBACK_TAG = 8'hEE;

    typedef logic [5:0] chan_word_t;

    // phase byte arrives first, so it sits in the low half
    typedef struct packed {
        logic [1:0] attn_pad;
        chan_word_t attn;
        logic [1:0] phase_pad;
        chan_word_t phase;
    } chan_pair_t;

    typedef struct packed {
        logic [3:0] rsvd_hi;
        logic       soft_inhibit;
        logic       tx_rx_sel;
        logic [1:0] rsvd_lo;
    } ctrl_byte_t;

    typedef struct packed {
        logic [7:0]              checksum;
        logic [7:0]              ch_power;
        chan_pair_t [NUM_CH-1:0] ch;
        ctrl_byte_t              ctrl;
    } frame_fields_t;

    // byte 0 of the frame is the lowest byte of the word
    typedef union packed {
        logic [FRAME_BYTES-1:0][7:0] bytes;
        frame_fields_t               fields;
    } frame_u;

endpackage

// File: verilog/uart_rx.sv
module uart_rx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic       i_clk,
    input  logic       w_rst_n,
    input  logic       i_rx_serial,
    output logic [7:0] o_byte,
    output logic       o_byte_valid
);

    localparam int CW = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CW-1:0] FULL_CNT = CW'(CLKS_PER_BIT - 1);
    localparam logic [CW-1:0] HALF_CNT = CW'((CLKS_PER_BIT - 1) / 2);

    localparam logic [1:0] RX_IDLE  = 2'd0;
    localparam logic [1:0] RX_START = 2'd1;
    localparam logic [1:0] RX_DATA  = 2'd2;
    localparam logic [1:0] RX_STOP  = 2'd3;

    logic          r_rx_meta;
    logic          r_rx_sync;
    logic [1:0]    r_state;
    logic [CW-1:0] r_clk_cnt;
    logic [2:0]    r_bit_idx;
    logic [7:0]    r_shift;

    always_ff @(posedge i_clk or negedge w_rst_n) begin
        if (!w_rst_n) begin
            r_rx_meta    <= 1'b1;
            r_rx_sync    <= 1'b1;
            r_state      <= RX_IDLE;
            r_clk_cnt    <= '0;
            r_bit_idx    <= '0;
            r_shift      <= '0;
            o_byte_valid <= 1'b0;
        end else begin
            r_rx_meta    <= i_rx_serial;
            r_rx_sync    <= r_rx_meta;
            o_byte_valid <= 1'b0;
            case (r_state)
                RX_IDLE: begin
                    r_clk_cnt <= '0;
                    if (!r_rx_sync) begin
                        r_state <= RX_START;
                    end
                end
                RX_START: begin
                    // confirm start at half a bit, else a glitch
                    if (r_clk_cnt == HALF_CNT) begin
                        r_clk_cnt <= '0;
                        r_state   <= r_rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        r_clk_cnt <= r_clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (r_clk_cnt == FULL_CNT) begin
                        r_clk_cnt <= '0;
                        r_shift   <= {r_rx_sync, r_shift[7:1]};
                        r_bit_idx <= r_bit_idx + 1'b1;
                        if (r_bit_idx == 3'd7) begin
                            r_state <= RX_STOP;
                        end
                    end else begin
                        r_clk_cnt <= r_clk_cnt + 1'b1;
                    end
                end
                default: begin
                    if (r_clk_cnt == FULL_CNT) begin
                        r_clk_cnt    <= '0;
                        o_byte_valid <= r_rx_sync;
                        r_state      <= RX_IDLE;
                    end else begin
                        r_clk_cnt <= r_clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    assign o_byte = r_shift;

endmodule

// File: verilog/uart_tx.sv
module uart_tx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic       i_clk,
    input  logic       w_rst_n,
    input  logic       i_tx_start,
    input  logic [7:0] i_tx_byte,
    output logic       o_tx_serial,
    output logic       o_tx_busy
);

    localparam int CW = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CW-1:0] FULL_CNT = CW'(CLKS_PER_BIT - 1);

    localparam logic [1:0] TX_IDLE  = 2'd0;
    localparam logic [1:0] TX_START = 2'd1;
    localparam logic [1:0] TX_DATA  = 2'd2;
    localparam logic [1:0] TX_STOP  = 2'd3;

    logic [1:0]    r_state;
    logic [CW-1:0] r_clk_cnt;
    logic [2:0]    r_bit_idx;
    logic [7:0]    r_shift;

    always_ff @(posedge i_clk or negedge w_rst_n) begin
        if (!w_rst_n) begin
            r_state     <= TX_IDLE;
            r_clk_cnt   <= '0;
            r_bit_idx   <= '0;
            r_shift     <= '0;
            o_tx_serial <= 1'b1;
            o_tx_busy   <= 1'b0;
        end else begin
            if (r_state == TX_IDLE) begin
                r_clk_cnt <= '0;
                r_bit_idx <= '0;
                if (i_tx_start) begin
                    r_shift     <= i_tx_byte;
                    o_tx_serial <= 1'b0;
                    o_tx_busy   <= 1'b1;
                    r_state     <= TX_START;
                end
            end else if (r_clk_cnt != FULL_CNT) begin
                r_clk_cnt <= r_clk_cnt + 1'b1;
            end else begin
                r_clk_cnt <= '0;
                case (r_state)
                    TX_START: begin
                        o_tx_serial <= r_shift[0];
                        r_shift     <= r_shift >> 1;
                        r_state     <= TX_DATA;
                    end
                    TX_DATA: begin
                        r_bit_idx <= r_bit_idx + 1'b1;
                        if (r_bit_idx == 3'd7) begin
                            o_tx_serial <= 1'b1;
                            r_state     <= TX_STOP;
                        end else begin
                            o_tx_serial <= r_shift[0];
                            r_shift     <= r_shift >> 1;
                        end
                    end
                    default: begin
                        // end of stop bit frees the line
                        o_tx_busy <= 1'b0;
                        r_state   <= TX_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

// File: verilog/frame_receiver.sv
module frame_receiver #(
    parameter int CLKS_PER_BIT = 868,
    parameter int GAP_BITS     = 20
) (
    input  logic              i_clk,
    input  logic              w_rst_n,
    input  logic [7:0]        i_byte,
    input  logic              i_byte_valid,
    output plank_pkg::frame_u o_frame,
    output logic              o_frame_valid
);

    localparam int GAP_CLKS = GAP_BITS * CLKS_PER_BIT;
    localparam int GW       = $clog2(GAP_CLKS + 1);

    localparam logic [GW-1:0] GAP_LAST = GW'(GAP_CLKS - 1);
    localparam logic [4:0]    CSUM_IDX = 5'(plank_pkg::PAYLOAD_BYTES);

    logic [4:0]    r_byte_cnt;
    logic [7:0]    r_sum;
    logic [GW-1:0] r_gap_cnt;

    // frame storage
    always_ff @(posedge i_clk) begin
        if (i_byte_valid) begin
            o_frame.bytes[r_byte_cnt] <= i_byte;
        end
    end

    always_ff @(posedge i_clk or negedge w_rst_n) begin
        if (!w_rst_n) begin
            r_byte_cnt    <= '0;
            r_sum         <= '0;
            r_gap_cnt     <= '0;
            o_frame_valid <= 1'b0;
        end else begin
            o_frame_valid <= 1'b0;
            if (i_byte_valid) begin
                r_gap_cnt <= '0;
                if (r_byte_cnt == CSUM_IDX) begin
                    // good or bad, the next byte starts a new frame
                    o_frame_valid <= (r_sum == i_byte);
                    r_byte_cnt    <= '0;
                    r_sum         <= '0;
                end else begin
                    r_byte_cnt <= r_byte_cnt + 1'b1;
                    r_sum      <= r_sum + i_byte;
                end
            end else if (r_byte_cnt != '0) begin
                if (r_gap_cnt == GAP_LAST) begin
                    r_gap_cnt  <= '0;
                    r_byte_cnt <= '0;
                    r_sum      <= '0;
                end else begin
                    r_gap_cnt <= r_gap_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: verilog/beam_control_regs.sv
module beam_control_regs (
    input  logic                                          i_clk,
    input  logic                                          w_rst_n,
    input  plank_pkg::frame_u                             i_frame,
    input  logic                                          i_frame_valid,
    input  logic                                          i_inhibit,
    input  logic                                          i_tr_pulse,
    input  logic                                          i_attn_31p5,
    input  logic                                          i_phase_180,
    output plank_pkg::chan_word_t [plank_pkg::NUM_CH-1:0] o_attn,
    output plank_pkg::chan_word_t [plank_pkg::NUM_CH-1:0] o_phase,
    output logic [7:0]                                    o_ch_power,
    output logic                                          o_tr_pulse,
    output logic                                          o_tx_rx_sel,
    output logic                                          o_loaded
);

    plank_pkg::chan_word_t [plank_pkg::NUM_CH-1:0] r_attn;
    plank_pkg::chan_word_t [plank_pkg::NUM_CH-1:0] r_phase;

    logic r_soft_inhibit;
    logic w_override;

    always_ff @(posedge i_clk or negedge w_rst_n) begin
        if (!w_rst_n) begin
            r_attn         <= '0;
            r_phase        <= '0;
            o_ch_power     <= '0;
            o_tx_rx_sel    <= 1'b0;
            r_soft_inhibit <= 1'b0;
            o_loaded       <= 1'b0;
        end else begin
            o_loaded <= i_frame_valid;
            if (i_frame_valid) begin
                for (int k = 0; k < plank_pkg::NUM_CH; k++) begin
                    r_phase[k] <= i_frame.fields.ch[k].phase;
                    r_attn[k]  <= i_frame.fields.ch[k].attn;
                end
                o_ch_power     <= i_frame.fields.ch_power;
                o_tx_rx_sel    <= i_frame.fields.ctrl.tx_rx_sel;
                r_soft_inhibit <= i_frame.fields.ctrl.soft_inhibit;
            end
        end
    end

    // hardware inhibit needs the soft enable too
    assign w_override = i_inhibit & r_soft_inhibit;

    always_comb begin
        for (int k = 0; k < plank_pkg::NUM_CH; k++) begin
            o_attn[k]  = w_override ? {6{i_attn_31p5}} : r_attn[k];
            o_phase[k] = w_override ? {i_phase_180, 5'b0} : r_phase[k];
        end
    end

    assign o_tr_pulse = w_override ? i_tr_pulse : o_tx_rx_sel;

endmodule

// File: verilog/feedback_sender.sv
module feedback_sender (
    input  logic       i_clk,
    input  logic       w_rst_n,
    input  logic       i_loaded,
    input  logic [7:0] i_ch_power,
    input  logic       i_tx_rx_sel,
    input  logic       i_tx_busy,
    output logic [7:0] o_tx_byte,
    output logic       o_tx_start
);

    localparam int RW = plank_pkg::FEEDBACK_BYTES * 8;
    localparam logic [1:0] LAST_IDX = 2'(plank_pkg::FEEDBACK_BYTES - 1);

    logic          r_pending;
    logic          r_active;
    logic [1:0]    r_byte_cnt;
    logic [RW-1:0] r_reply;
    logic          w_snap;
    logic          w_issue;

    assign w_snap  = !r_active && r_pending;
    // busy only rises the clock after a start
    assign w_issue = r_active && !i_tx_busy && !o_tx_start;

    always_ff @(posedge i_clk) begin
        if (w_snap) begin
            r_reply <= {7'b0, i_tx_rx_sel, i_ch_power, plank_pkg::FEEDBACK_TAG};
        end else if (w_issue) begin
            o_tx_byte <= r_reply[7:0];
            r_reply   <= r_reply >> 8;
        end
    end

    always_ff @(posedge i_clk or negedge w_rst_n) begin
        if (!w_rst_n) begin
            r_pending  <= 1'b0;
            r_active   <= 1'b0;
            r_byte_cnt <= '0;
            o_tx_start <= 1'b0;
        end else begin
            o_tx_start <= w_issue;
            if (w_snap) begin
                r_pending  <= i_loaded;
                r_active   <= 1'b1;
                r_byte_cnt <= '0;
            end else begin
                r_pending <= r_pending | i_loaded;
                if (w_issue) begin
                    r_byte_cnt <= r_byte_cnt + 1'b1;
                    if (r_byte_cnt == LAST_IDX) begin
                        r_active <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

// File: verilog/plank_top.sv
module plank_top #(
    parameter int CLKS_PER_BIT = 868,
    parameter int GAP_BITS     = 20
) (
    input  logic                                          i_clk,
    input  logic                                          w_rst_n,
    input  logic                                          i_rx_serial,
    input  logic                                          i_inhibit,
    input  logic                                          i_tr_pulse,
    input  logic                                          i_attn_31p5,
    input  logic                                          i_phase_180,
    output logic                                          o_tx_serial,
    output logic [7:0]                                    o_ch_power,
    output plank_pkg::chan_word_t [plank_pkg::NUM_CH-1:0] o_attn,
    output plank_pkg::chan_word_t [plank_pkg::NUM_CH-1:0] o_phase,
    output logic                                          o_tr_pulse
);

    logic [7:0]        w_rx_byte;
    logic              w_rx_byte_valid;
    plank_pkg::frame_u w_frame;
    logic              w_frame_valid;
    logic              w_loaded;
    logic              w_tx_rx_sel;
    logic [7:0]        w_tx_byte;
    logic              w_tx_start;
    logic              w_tx_busy;

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
        .i_clk        (i_clk),
        .w_rst_n      (w_rst_n),
        .i_rx_serial  (i_rx_serial),
        .o_byte       (w_rx_byte),
        .o_byte_valid (w_rx_byte_valid)
    );

    frame_receiver #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .GAP_BITS     (GAP_BITS)
    ) u_frame_receiver (
        .i_clk         (i_clk),
        .w_rst_n       (w_rst_n),
        .i_byte        (w_rx_byte),
        .i_byte_valid  (w_rx_byte_valid),
        .o_frame       (w_frame),
        .o_frame_valid (w_frame_valid)
    );

    beam_control_regs u_beam_control_regs (
        .i_clk         (i_clk),
        .w_rst_n       (w_rst_n),
        .i_frame       (w_frame),
        .i_frame_valid (w_frame_valid),
        .i_inhibit     (i_inhibit),
        .i_tr_pulse    (i_tr_pulse),
        .i_attn_31p5   (i_attn_31p5),
        .i_phase_180   (i_phase_180),
        .o_attn        (o_attn),
        .o_phase       (o_phase),
        .o_ch_power    (o_ch_power),
        .o_tr_pulse    (o_tr_pulse),
        .o_tx_rx_sel   (w_tx_rx_sel),
        .o_loaded      (w_loaded)
    );

    feedback_sender u_feedback_sender (
        .i_clk       (i_clk),
        .w_rst_n     (w_rst_n),
        .i_loaded    (w_loaded),
        .i_ch_power  (o_ch_power),
        .i_tx_rx_sel (w_tx_rx_sel),
        .i_tx_busy   (w_tx_busy),
        .o_tx_byte   (w_tx_byte),
        .o_tx_start  (w_tx_start)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
        .i_clk       (i_clk),
        .w_rst_n     (w_rst_n),
        .i_tx_start  (w_tx_start),
        .i_tx_byte   (w_tx_byte),
        .o_tx_serial (o_tx_serial),
        .o_tx_busy   (w_tx_busy)
    );

endmodule

// File: dv/plank_tb.sv
module plank_tb;

    localparam int CLKS_PER_BIT = 16;
    localparam int GAP_BITS     = 20;
    localparam int MAX_CASES    = 32;
    localparam int PAY_BYTES    = 18;
    localparam int WAIT_BITS    = 40;

    logic       i_clk;
    logic       w_rst_n;
    logic       i_rx_serial;
    logic       i_inhibit;
    logic       i_tr_pulse;
    logic       i_attn_31p5;
    logic       i_phase_180;
    logic       o_tx_serial;
    logic [7:0] o_ch_power;
    logic       o_tr_pulse;

    plank_pkg::chan_word_t [plank_pkg::NUM_CH-1:0] o_attn;
    plank_pkg::chan_word_t [plank_pkg::NUM_CH-1:0] o_phase;

    // case table
    logic [7:0] cs_flag [0:MAX_CASES-1][0:5];
    logic [7:0] cs_pay  [0:MAX_CASES-1][0:PAY_BYTES-1];
    int         n_cases = 0;

    // last good frame, as the outputs should hold it
    logic [5:0] m_phase [0:7];
    logic [5:0] m_attn  [0:7];
    logic [7:0] m_power;
    logic       m_sel;
    logic       m_soft;

    logic [7:0] cur_pay [0:PAY_BYTES-1];
    logic [7:0] reply_q [$];
    int         error_count = 0;
    int         check_count = 0;
    int         cycle_count = 0;
    int         cycle_limit = 0;
    integer     seed;
    logic       file_ok;

    plank_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .GAP_BITS     (GAP_BITS)
    ) i_dut (
        .i_clk       (i_clk),
        .w_rst_n     (w_rst_n),
        .i_rx_serial (i_rx_serial),
        .i_inhibit   (i_inhibit),
        .i_tr_pulse  (i_tr_pulse),
        .i_attn_31p5 (i_attn_31p5),
        .i_phase_180 (i_phase_180),
        .o_tx_serial (o_tx_serial),
        .o_ch_power  (o_ch_power),
        .o_attn      (o_attn),
        .o_phase     (o_phase),
        .o_tr_pulse  (o_tr_pulse)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s = %0h, expected %0h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic wait_bits(input int bits);
        repeat (bits * CLKS_PER_BIT) @(negedge i_clk);
    endtask

    task automatic send_byte(input logic [7:0] data);
        i_rx_serial = 1'b0;
        wait_bits(1);
        for (int b = 0; b < 8; b++) begin
            i_rx_serial = data[b];
            wait_bits(1);
        end
        i_rx_serial = 1'b1;
        wait_bits(1);
    endtask

    task automatic receive_reply_byte();
        logic [7:0] data;
        repeat (CLKS_PER_BIT / 2) @(negedge i_clk);
        if (o_tx_serial !== 1'b0) begin
            error_count++;
            $display("reply start bit at %0t did not stay low", $time);
        end else begin
            for (int b = 0; b < 8; b++) begin
                wait_bits(1);
                data[b] = o_tx_serial;
            end
            wait_bits(1);
            if (o_tx_serial !== 1'b1) begin
                error_count++;
                $display("reply stop bit at %0t was not high", $time);
            end else begin
                reply_q.push_back(data);
            end
        end
    endtask

    // reply line monitor
    initial begin
        @(posedge w_rst_n);
        forever begin
            @(negedge i_clk);
            if (o_tx_serial === 1'b0) begin
                receive_reply_byte();
            end
        end
    end

    task automatic check_outputs();
        logic       override;
        logic [5:0] exp_attn;
        logic [5:0] exp_phase;
        override = i_inhibit & m_soft;
        for (int k = 0; k < plank_pkg::NUM_CH; k++) begin
            exp_attn  = override ? {6{i_attn_31p5}} : m_attn[k];
            exp_phase = override ? {i_phase_180, 5'b0} : m_phase[k];
            check_value($sformatf("o_attn[%0d]", k), 32'(o_attn[k]), 32'(exp_attn));
            check_value($sformatf("o_phase[%0d]", k), 32'(o_phase[k]), 32'(exp_phase));
        end
        check_value("o_ch_power", 32'(o_ch_power), 32'(m_power));
        check_value("o_tr_pulse", 32'(o_tr_pulse), 32'(override ? i_tr_pulse : m_sel));
        check_value("o_tx_serial", 32'(o_tx_serial), 32'd1);
    endtask

    task automatic run_frame(input logic good, input logic gap, input logic inh,
                             input logic a31, input logic p180, input logic trp);
        logic [7:0] sum;
        sum         = 8'h00;
        i_inhibit   = inh;
        i_attn_31p5 = a31;
        i_phase_180 = p180;
        i_tr_pulse  = trp;
        for (int j = 0; j < PAY_BYTES; j++) begin
            sum = sum + cur_pay[j];
        end
        if (!good) begin
            sum = ~sum;
        end
        reply_q.delete();
        if (gap) begin
            // partial frame, then silence past the gap limit
            for (int j = 0; j < 7; j++) begin
                send_byte(cur_pay[j]);
            end
            wait_bits(GAP_BITS + 4);
        end
        for (int j = 0; j < PAY_BYTES; j++) begin
            send_byte(cur_pay[j]);
        end
        send_byte(sum);
        wait_bits(WAIT_BITS);
        if (good) begin
            for (int k = 0; k < plank_pkg::NUM_CH; k++) begin
                m_phase[k] = cur_pay[2 * k + 1][5:0];
                m_attn[k]  = cur_pay[2 * k + 2][5:0];
            end
            m_power = cur_pay[17];
            m_sel   = cur_pay[0][2];
            m_soft  = cur_pay[0][3];
            check_value("reply byte count", reply_q.size(), 32'd3);
            if (reply_q.size() == 3) begin
                check_value("reply[0]", 32'(reply_q[0]), 32'h00EE);
                check_value("reply[1]", 32'(reply_q[1]), 32'(cur_pay[17]));
                check_value("reply[2]", 32'(reply_q[2]), 32'(cur_pay[0][2]));
            end
        end else begin
            check_value("reply byte count", reply_q.size(), 32'd0);
        end
        check_outputs();
        // other side of the override
        i_inhibit = ~i_inhibit;
        @(negedge i_clk);
        check_outputs();
    endtask

    task automatic load_cases(output logic ok);
        int         fd;
        int         rc;
        string      line;
        logic [7:0] f [0:5];
        logic [7:0] b [0:PAY_BYTES-1];
        fd = $fopen("dv/plank_cases.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                rc = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5],
                    b[0], b[1], b[2], b[3], b[4], b[5], b[6], b[7], b[8],
                    b[9], b[10], b[11], b[12], b[13], b[14], b[15], b[16], b[17]);
                if (rc != 24 || n_cases >= MAX_CASES) begin
                    error_count++;
                    $display("case line could not be used: %s", line);
                end else begin
                    cs_flag[n_cases] = f;
                    cs_pay[n_cases]  = b;
                    n_cases++;
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        w_rst_n     = 1'b0;
        i_rx_serial = 1'b1;
        i_inhibit   = 1'b0;
        i_tr_pulse  = 1'b0;
        i_attn_31p5 = 1'b0;
        i_phase_180 = 1'b0;
        seed        = 32'h2d1;
        m_power     = 8'h00;
        m_sel       = 1'b0;
        m_soft      = 1'b0;
        for (int k = 0; k < 8; k++) begin
            m_phase[k] = 6'd0;
            m_attn[k]  = 6'd0;
        end
        load_cases(file_ok);
        if (!file_ok) begin
            $display("could not open the case file dv/plank_cases.txt");
            $display("Simulation FAILED");
            $finish;
        end else begin
            // frame in plus reply, ten bits a byte, twice over
            cycle_limit = (n_cases + 1) * (19 + 3) * 10 * CLKS_PER_BIT * 2;
            repeat (16) @(negedge i_clk);
            w_rst_n = 1'b1;
            repeat (4) @(negedge i_clk);
            check_outputs();
            for (int i = 0; i < n_cases; i++) begin
                cur_pay = cs_pay[i];
                run_frame(cs_flag[i][0][0], cs_flag[i][1][0], cs_flag[i][2][0],
                          cs_flag[i][3][0], cs_flag[i][4][0], cs_flag[i][5][0]);
            end
            for (int j = 0; j < PAY_BYTES; j++) begin
                cur_pay[j] = 8'($random(seed));
            end
            run_frame(1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1);
            $display("frames: %0d, checks: %0d, errors: %0d",
                     n_cases + 1, check_count, error_count);
            if (error_count == 0) begin
                $display("Simulation PASSED");
            end else begin
                $display("Simulation FAILED");
            end
            $finish;
        end
    end

endmodule

// File: dv/plank_cases.txt
# good gap inhibit attn_31p5 phase_180 tr_pulse, then payload bytes 0..17, all hex
# byte 0 bit 2 is tx_rx_sel and bit 3 soft_inhibit, byte 2k+1 phase, 2k+2 attn, 17 power
1 0 0 0 0 0 04 11 22 33 04 3f 15 2a 01 c7 38 05 0a 10 20 30 3c a5
1 0 1 1 1 1 04 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 7f
0 0 0 0 0 0 0c ff ee dd cc bb aa 99 88 77 66 55 44 33 22 11 00 42
1 0 1 1 1 1 08 21 12 23 14 25 16 27 18 29 1a 2b 1c 2d 1e 2f 10 81
1 0 1 0 1 0 0c 3a 05 3b 06 3c 07 3d 08 3e 09 3f 0a 30 0b 31 0c 5a
1 1 0 0 0 0 04 40 81 c2 03 44 85 c6 07 48 89 ca 0b 4c 8d ce 0f 99
0 0 1 1 0 1 08 1f 1f 1f 1f 1f 1f 1f 1f 1f 1f 1f 1f 1f 1f 1f 1f 33
1 1 1 0 1 1 0f 3f 00 00 3f 2a 15 15 2a 01 02 03 04 05 06 07 08 fe
1 0 0 0 0 0 00 05 05 05 05 05 05 05 05 05 05 05 05 05 05 05 05 00

// File: flist.f
verilog/plank_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/frame_receiver.sv
verilog/beam_control_regs.sv
verilog/feedback_sender.sv
verilog/plank_top.sv
dv/plank_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= plank_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "run passed"; \
	else \
		echo "run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
